// File: list.f
src/corebus_pkg.sv
src/instr_port.sv
src/data_port.sv
src/bus_arbiter.sv
src/corebus_top.sv
bench/bus_memory.sv
bench/corebus_assertions.sv
bench/corebus_tb.sv

// File: Bender.yml
package:
  name: corebus

sources:
  - src/corebus_pkg.sv
  - src/instr_port.sv
  - src/data_port.sv
  - src/bus_arbiter.sv
  - src/corebus_top.sv
  - target: test
    files:
      - bench/bus_memory.sv
      - bench/corebus_assertions.sv
      - bench/corebus_tb.sv

// File: bench/corebus_tb.sv
`timescale 1ns/1ps

module corebus_tb
    import corebus_pkg::*;
();

    localparam int mem_words    = 256;
    localparam int reset_cycles = 16;
    localparam int n_random     = 200;
    localparam int n_directed   = 40;  // Transfers outside the random test
    localparam int max_cycles   = (n_random + n_directed) * 10 + reset_cycles;

    logic              clk_core;
    logic              rst_n_i;
    logic              instr_req_i;
    logic [addr_w-1:0] instr_addr_i;
    logic [data_w-1:0] instr_o;
    logic              instr_valid_o;
    logic              instr_busy_o;
    logic              data_req_i;
    logic [addr_w-1:0] data_addr_i;
    logic [data_w-1:0] data_wdata_i;
    logic [strb_w-1:0] data_wmask_i;
    logic              data_wen_n_i;
    logic [data_w-1:0] data_rdata_o;
    logic              data_done_o;
    logic              data_busy_o;
    logic              mem_cyc_o;
    logic              mem_stb_o;
    logic              mem_we_o;
    logic [strb_w-1:0] mem_wstrb_o;
    logic [addr_w-1:0] mem_addr_o;
    logic [data_w-1:0] mem_wdata_o;
    logic [data_w-1:0] mem_rdata_i;
    logic              mem_ack_i;

    logic [data_w-1:0] shadow [mem_words];  // Expected memory contents
    int                cycle_cnt = 0;
    int                n_tests   = 0;
    int                n_failed  = 0;
    int                n_checks  = 0;
    int                test_errs = 0;

    corebus_top u_corebus_top (.*);

    bus_memory u_bus_memory (
        .clk_core    (clk_core),
        .rst_n_i     (rst_n_i),
        .mem_cyc_i   (mem_cyc_o),
        .mem_stb_i   (mem_stb_o),
        .mem_we_i    (mem_we_o),
        .mem_wstrb_i (mem_wstrb_o),
        .mem_addr_i  (mem_addr_o),
        .mem_wdata_i (mem_wdata_o),
        .mem_rdata_o (mem_rdata_i),
        .mem_ack_o   (mem_ack_i)
    );

    initial clk_core = 1'b0;
    always #10 clk_core = ~clk_core;

    always @(posedge clk_core) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == max_cycles) begin
            $display("Timeout, no result after %0d cycles", max_cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // Preload pattern that mixes every index bit into the word
    function automatic logic [data_w-1:0] fill_word(input int idx);
        return (32'h9e37_79b9 * (idx + 1)) ^ (idx << 16);
    endfunction

    task automatic check_value(input string name, input logic [data_w-1:0] expected,
                               input logic [data_w-1:0] actual);
        n_checks++;
        assert (actual === expected)
        else begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            test_errs++;
        end
    endtask

    task automatic shadow_store(input int idx, input logic [data_w-1:0] wdata,
                                input logic [strb_w-1:0] mask);
        for (int b = 0; b < strb_w; b++) begin
            if (mask[b]) begin
                shadow[idx][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    endtask

    task automatic fetch(input string name, input int idx);
        @(posedge clk_core);
        instr_req_i  <= 1'b1;
        instr_addr_i <= idx << 2;
        @(posedge clk_core);
        instr_req_i <= 1'b0;
        @(negedge clk_core);
        check_value(name, 1, instr_busy_o);  // Busy from the strobe edge on
        do @(negedge clk_core); while (!instr_valid_o);
        check_value(name, shadow[idx], instr_o);
    endtask

    task automatic data_access(input string name, input int idx, input logic store,
                               input logic [data_w-1:0] wdata, input logic [strb_w-1:0] mask);
        @(posedge clk_core);
        data_req_i   <= 1'b1;
        data_addr_i  <= idx << 2;
        data_wen_n_i <= ~store;
        data_wdata_i <= wdata;
        data_wmask_i <= mask;
        @(posedge clk_core);
        data_req_i <= 1'b0;
        do @(negedge clk_core); while (!data_done_o);
        if (store) begin
            shadow_store(idx, wdata, mask);
        end else begin
            check_value(name, shadow[idx], data_rdata_o);
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (test_errs == 0) begin
            $display("test %-10s done, ok", name);
        end else begin
            $display("test %-10s done, %0d errors", name, test_errs);
            n_failed++;
        end
        test_errs = 0;
    endtask

    initial begin
        int t;
        int t_i;
        int t_d;
        int pulses;
        int unsigned a_fails;
        void'($urandom(32'hb371));
        rst_n_i      = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        data_wmask_i = '0;
        data_wen_n_i = 1'b1;
        for (int i = 0; i < mem_words; i++) begin
            shadow[i]           = fill_word(i);
            u_bus_memory.mem[i] = shadow[i];
        end
        repeat (reset_cycles) @(posedge clk_core);
        rst_n_i <= 1'b1;

        for (int k = 0; k < 8; k++) begin
            fetch("fetch", (k * 37 + 3) % mem_words);
        end
        end_test("fetch");

        for (int k = 0; k < 3; k++) begin
            data_access("full_word", 20 + k, 1'b1, $urandom, 4'hf);
            data_access("full_word", 20 + k, 1'b0, '0, '0);
        end
        end_test("full_word");

        for (int k = 0; k < 6; k++) begin
            data_access("byte_strb", 40 + k, 1'b1, $urandom, 4'($urandom_range(1, 14)));
            data_access("byte_strb", 40 + k, 1'b0, '0, '0);
        end
        end_test("byte_strb");

        // Data wins the bus when a fetch and a load are strobed together
        for (int k = 0; k < 4; k++) begin
            @(posedge clk_core);
            instr_req_i  <= 1'b1;
            instr_addr_i <= (100 + k) << 2;
            data_req_i   <= 1'b1;
            data_addr_i  <= (40 + k) << 2;
            data_wen_n_i <= 1'b1;
            @(posedge clk_core);
            instr_req_i <= 1'b0;
            data_req_i  <= 1'b0;
            t   = 0;
            t_i = 0;
            t_d = 0;
            while (t_i == 0 || t_d == 0) begin
                @(negedge clk_core);
                t++;
                if (data_done_o) begin
                    t_d = t;
                    check_value("same_cycle", shadow[40 + k], data_rdata_o);
                end
                if (instr_valid_o) begin
                    t_i = t;
                    check_value("same_cycle", shadow[100 + k], instr_o);
                end
            end
            if (t_d > t_i) begin
                $display("same_cycle: load finished after the fetch it should precede");
                test_errs++;
            end
        end
        end_test("same_cycle");

        @(posedge clk_core);
        data_req_i   <= 1'b1;
        data_addr_i  <= 60 << 2;
        data_wen_n_i <= 1'b0;
        data_wdata_i <= 32'h1234_5678;
        data_wmask_i <= 4'hf;
        @(posedge clk_core);
        data_req_i <= 1'b0;
        @(negedge clk_core);
        check_value("busy", 1, data_busy_o);
        // Second store sampled in the cycle between the ack and the done pulse
        while (!mem_ack_i) begin
            @(negedge clk_core);
        end
        @(posedge clk_core);
        data_req_i   <= 1'b1;
        data_addr_i  <= 61 << 2;
        data_wdata_i <= 32'hdead_0bad;
        @(negedge clk_core);
        check_value("busy", 1, data_busy_o);
        @(posedge clk_core);
        data_req_i <= 1'b0;
        do @(negedge clk_core); while (!data_done_o);
        shadow_store(60, 32'h1234_5678, 4'hf);
        pulses = 0;
        repeat (8) begin
            @(negedge clk_core);
            pulses += data_done_o;
        end
        check_value("busy", 0, pulses);
        data_access("busy", 60, 1'b0, '0, '0);
        data_access("busy", 61, 1'b0, '0, '0);
        end_test("busy");

        for (int n = 0; n < n_random; n++) begin
            t = $urandom_range(0, mem_words - 1);
            case ($urandom_range(0, 2))
                0: fetch("random", t);
                1: data_access("random", t, 1'b0, '0, '0);
                default: data_access("random", t, 1'b1, $urandom, 4'($urandom_range(1, 15)));
            endcase
        end
        end_test("random");

        a_fails = u_corebus_top.u_corebus_assertions.fail_cnt;
        $display("%0d tests, %0d passed, %0d failed, %0d value checks, %0d assertion failures",
                 n_tests, n_tests - n_failed, n_failed, n_checks, a_fails);
        if (n_failed == 0 && a_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: bench/corebus_assertions.sv
`timescale 1ns/1ps

module corebus_assertions
    import corebus_pkg::*;
(
    input logic              clk_core,
    input logic              rst_n_i,
    input logic              mem_cyc_o,
    input logic              mem_stb_o,
    input logic              mem_we_o,
    input logic [strb_w-1:0] mem_wstrb_o,
    input logic [addr_w-1:0] mem_addr_o,
    input logic [data_w-1:0] mem_wdata_o,
    input logic              mem_ack_i,
    input logic              iack,
    input logic              dack,
    input logic              instr_valid_o,
    input logic              data_done_o,
    input logic              instr_busy_o,
    input logic              data_busy_o
);

    int unsigned fail_cnt = 0;  // Total of failed assertions

    stb_in_cyc: assert property (@(posedge clk_core) disable iff (!rst_n_i)
        mem_stb_o |-> mem_cyc_o)
        else begin
            $error("mem_stb_o high outside a bus cycle");
            fail_cnt++;
        end

    // Request held until the memory answers
    bus_held: assert property (@(posedge clk_core) disable iff (!rst_n_i)
        mem_stb_o && !mem_ack_i |=> mem_stb_o && mem_we_o === $past(mem_we_o)
            && mem_wstrb_o === $past(mem_wstrb_o) && mem_addr_o === $past(mem_addr_o)
            && mem_wdata_o === $past(mem_wdata_o))
        else begin
            $error("bus request changed or dropped before mem_ack_i");
            fail_cnt++;
        end

    single_pulse: assert property (@(posedge clk_core) disable iff (!rst_n_i)
        (instr_valid_o |=> !instr_valid_o) and (data_done_o |=> !data_done_o))
        else begin
            $error("valid or done pulse longer than one cycle");
            fail_cnt++;
        end

    // Ack two edges before the pulse
    pulse_after_ack: assert property (@(posedge clk_core) disable iff (!rst_n_i)
        (instr_valid_o |-> $past(iack, 2)) and (data_done_o |-> $past(dack, 2)))
        else begin
            $error("valid or done pulse without a granted ack");
            fail_cnt++;
        end

    reset_quiet: assert property (@(posedge clk_core)
        $rose(rst_n_i) |-> !(mem_cyc_o || mem_stb_o || mem_we_o || instr_valid_o
            || data_done_o || instr_busy_o || data_busy_o))
        else begin
            $error("output high in the first cycle after reset");
            fail_cnt++;
        end

endmodule

bind corebus_top corebus_assertions u_corebus_assertions (.*);

// File: bench/bus_memory.sv
`timescale 1ns/1ps

module bus_memory
    import corebus_pkg::*;
(
    input  logic              clk_core,
    input  logic              rst_n_i,
    input  logic              mem_cyc_i,
    input  logic              mem_stb_i,
    input  logic              mem_we_i,
    input  logic [strb_w-1:0] mem_wstrb_i,
    input  logic [addr_w-1:0] mem_addr_i,
    input  logic [data_w-1:0] mem_wdata_i,
    output logic [data_w-1:0] mem_rdata_o,
    output logic              mem_ack_o
);

    logic [data_w-1:0] mem [256];  // 1 KiB, word addressed
    logic [7:0]        idx;
    logic [1:0]        wait_q;     // Wait cycles spent so far
    logic [1:0]        delay_q;    // Wait cycles drawn for this access

    assign idx         = mem_addr_i[9:2];
    assign mem_ack_o   = mem_cyc_i & mem_stb_i & (wait_q == delay_q);
    assign mem_rdata_o = mem[idx];

    always_ff @(posedge clk_core) begin
        if (!rst_n_i) begin
            wait_q  <= '0;
            delay_q <= '0;
        end else if (mem_ack_o) begin
            wait_q  <= '0;
            delay_q <= 2'($urandom_range(0, 3));  // Next access gets 0 to 3 waits
        end else if (mem_stb_i) begin
            wait_q <= wait_q + 2'd1;
        end
    end

    // Byte lanes written on the ack edge
    always @(posedge clk_core) begin
        if (mem_ack_o && mem_we_i) begin
            for (int b = 0; b < strb_w; b++) begin
                if (mem_wstrb_i[b]) begin
                    mem[idx][8*b +: 8] <= mem_wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: src/corebus_top.sv
`timescale 1ns/1ps

module corebus_top
    import corebus_pkg::*;
(
    input  logic              clk_core,
    input  logic              rst_n_i,

    // Core fetch port
    input  logic              instr_req_i,
    input  logic [addr_w-1:0] instr_addr_i,
    output logic [data_w-1:0] instr_o,
    output logic              instr_valid_o,
    output logic              instr_busy_o,

    // Core data port
    input  logic              data_req_i,
    input  logic [addr_w-1:0] data_addr_i,
    input  logic [data_w-1:0] data_wdata_i,
    input  logic [strb_w-1:0] data_wmask_i,
    input  logic              data_wen_n_i,
    output logic [data_w-1:0] data_rdata_o,
    output logic              data_done_o,
    output logic              data_busy_o,

    // Shared memory, Wishbone classic
    output logic              mem_cyc_o,
    output logic              mem_stb_o,
    output logic              mem_we_o,
    output logic [strb_w-1:0] mem_wstrb_o,
    output logic [addr_w-1:0] mem_addr_o,
    output logic [data_w-1:0] mem_wdata_o,
    input  logic [data_w-1:0] mem_rdata_i,
    input  logic              mem_ack_i
);

    logic              ireq;
    logic [addr_w-1:0] iaddr;
    logic              iack;
    logic              dreq;
    logic [addr_w-1:0] daddr;
    logic [data_w-1:0] dwdata;
    logic [strb_w-1:0] dwstrb;
    mem_op_e           dop;
    logic              dack;
    logic [data_w-1:0] rdata;

    instr_port u_instr_port (
        .clk_core      (clk_core),
        .rst_n_i       (rst_n_i),
        .instr_req_i   (instr_req_i),
        .instr_addr_i  (instr_addr_i),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .instr_busy_o  (instr_busy_o),
        .req_o         (ireq),
        .addr_o        (iaddr),
        .ack_i         (iack),
        .rdata_i       (rdata)
    );

    data_port u_data_port (
        .clk_core      (clk_core),
        .rst_n_i       (rst_n_i),
        .data_req_i    (data_req_i),
        .data_addr_i   (data_addr_i),
        .data_wdata_i  (data_wdata_i),
        .data_wmask_i  (data_wmask_i),
        .data_wen_n_i  (data_wen_n_i),
        .data_rdata_o  (data_rdata_o),
        .data_done_o   (data_done_o),
        .data_busy_o   (data_busy_o),
        .req_o         (dreq),
        .addr_o        (daddr),
        .wdata_o       (dwdata),
        .wstrb_o       (dwstrb),
        .op_o          (dop),
        .ack_i         (dack),
        .rdata_i       (rdata)
    );

    bus_arbiter u_bus_arbiter (
        .clk_core      (clk_core),
        .rst_n_i       (rst_n_i),
        .ireq_i        (ireq),
        .iaddr_i       (iaddr),
        .iack_o        (iack),
        .dreq_i        (dreq),
        .daddr_i       (daddr),
        .dwdata_i      (dwdata),
        .dwstrb_i      (dwstrb),
        .dop_i         (dop),
        .dack_o        (dack),
        .rdata_o       (rdata),
        .mem_cyc_o     (mem_cyc_o),
        .mem_stb_o     (mem_stb_o),
        .mem_we_o      (mem_we_o),
        .mem_wstrb_o   (mem_wstrb_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_rdata_i   (mem_rdata_i),
        .mem_ack_i     (mem_ack_i)
    );

endmodule

// File: src/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
    import corebus_pkg::*;
(
    input  logic              clk_core,
    input  logic              rst_n_i,

    // Instruction adapter
    input  logic              ireq_i,
    input  logic [addr_w-1:0] iaddr_i,
    output logic              iack_o,

    // Data adapter
    input  logic              dreq_i,
    input  logic [addr_w-1:0] daddr_i,
    input  logic [data_w-1:0] dwdata_i,
    input  logic [strb_w-1:0] dwstrb_i,
    input  mem_op_e           dop_i,
    output logic              dack_o,

    // Shared read data for both adapters
    output logic [data_w-1:0] rdata_o,

    // Memory bus
    output logic              mem_cyc_o,
    output logic              mem_stb_o,
    output logic              mem_we_o,
    output logic [strb_w-1:0] mem_wstrb_o,
    output logic [addr_w-1:0] mem_addr_o,
    output logic [data_w-1:0] mem_wdata_o,
    input  logic [data_w-1:0] mem_rdata_i,
    input  logic              mem_ack_i
);

    arb_state_e        state_q;
    arb_state_e        state_d;
    mem_op_e           op_q;
    logic [addr_w-1:0] addr_q;
    logic [data_w-1:0] wdata_q;
    logic [strb_w-1:0] wstrb_q;
    logic              grant_i;
    logic              grant_d;

    // Fixed priority, data first
    assign grant_d = (state_q == arb_idle) & dreq_i;
    assign grant_i = (state_q == arb_idle) & ~dreq_i & ireq_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            arb_idle: begin
                if (dreq_i) begin
                    state_d = arb_data;
                end else if (ireq_i) begin
                    state_d = arb_instr;
                end
            end
            arb_instr,
            arb_data: begin
                if (mem_ack_i) begin
                    state_d = arb_idle;  // No preemption before the ack
                end
            end
            default: state_d = arb_idle;
        endcase
    end

    always_ff @(posedge clk_core) begin
        if (!rst_n_i) begin
            state_q <= arb_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Bus payload frozen at grant time
    always_ff @(posedge clk_core) begin
        if (grant_d) begin
            addr_q  <= daddr_i;
            wdata_q <= dwdata_i;
            wstrb_q <= dwstrb_i;
            op_q    <= dop_i;
        end else if (grant_i) begin
            addr_q  <= iaddr_i;
            wstrb_q <= {strb_w{1'b1}};
            op_q    <= op_read;      // Fetches never write
        end
    end

    assign mem_cyc_o   = (state_q != arb_idle);
    assign mem_stb_o   = mem_cyc_o;
    assign mem_we_o    = mem_cyc_o & (op_q == op_write);
    assign mem_wstrb_o = wstrb_q;
    assign mem_addr_o  = addr_q;
    assign mem_wdata_o = wdata_q;

    // Ack steered to the owner only
    assign iack_o  = mem_ack_i & (state_q == arb_instr);
    assign dack_o  = mem_ack_i & (state_q == arb_data);
    assign rdata_o = mem_rdata_i;

endmodule

// File: src/data_port.sv
`timescale 1ns/1ps

module data_port
    import corebus_pkg::*;
(
    input  logic              clk_core,
    input  logic              rst_n_i,

    // Core data side
    input  logic              data_req_i,    // One-cycle strobe
    input  logic [addr_w-1:0] data_addr_i,
    input  logic [data_w-1:0] data_wdata_i,
    input  logic [strb_w-1:0] data_wmask_i,
    input  logic              data_wen_n_i,  // Low for a store
    output logic [data_w-1:0] data_rdata_o,
    output logic              data_done_o,   // Ends loads and stores
    output logic              data_busy_o,

    // Arbiter side
    output logic              req_o,
    output logic [addr_w-1:0] addr_o,
    output logic [data_w-1:0] wdata_o,
    output logic [strb_w-1:0] wstrb_o,
    output mem_op_e           op_o,
    input  logic              ack_i,
    input  logic [data_w-1:0] rdata_i
);

    logic              pending_q;
    logic              ack_seen_q;
    logic [addr_w-1:0] addr_q;
    logic [data_w-1:0] wdata_q;
    logic [strb_w-1:0] wstrb_q;
    mem_op_e           op_q;
    mem_op_e           op_in;
    logic [data_w-1:0] load_q;
    logic              accept;

    assign data_busy_o = pending_q | ack_seen_q;
    assign accept      = data_req_i & ~data_busy_o;

    // Active-low write enable to opcode
    assign op_in = data_wen_n_i ? op_read : op_write;

    always_ff @(posedge clk_core) begin
        if (!rst_n_i) begin
            pending_q  <= 1'b0;
            ack_seen_q <= 1'b0;
        end else begin
            ack_seen_q <= pending_q & ack_i;
            if (ack_i) begin
                pending_q <= 1'b0;
            end else if (accept) begin
                pending_q <= 1'b1;
            end
        end
    end

    // Whole transfer latched on the strobe
    always_ff @(posedge clk_core) begin
        if (accept) begin
            addr_q  <= data_addr_i;
            wdata_q <= data_wdata_i;
            op_q    <= op_in;
            // Loads always fetch the full word
            wstrb_q <= (op_in == op_read) ? {strb_w{1'b1}} : data_wmask_i;
        end
    end

    always_ff @(posedge clk_core) begin
        if (pending_q && ack_i && op_q == op_read) begin
            load_q <= rdata_i;
        end
    end

    always_ff @(posedge clk_core) begin
        if (!rst_n_i) begin
            data_done_o <= 1'b0;
        end else begin
            data_done_o <= ack_seen_q;
        end
    end

    // Store leaves the last load word in place
    always_ff @(posedge clk_core) begin
        if (ack_seen_q && op_q == op_read) begin
            data_rdata_o <= load_q;
        end
    end

    assign req_o   = pending_q;
    assign addr_o  = addr_q;
    assign wdata_o = wdata_q;
    assign wstrb_o = wstrb_q;
    assign op_o    = op_q;

endmodule

// File: src/instr_port.sv
`timescale 1ns/1ps

module instr_port
    import corebus_pkg::*;
(
    input  logic              clk_core,
    input  logic              rst_n_i,

    // Core fetch side
    input  logic              instr_req_i,    // One-cycle strobe
    input  logic [addr_w-1:0] instr_addr_i,
    output logic [data_w-1:0] instr_o,
    output logic              instr_valid_o,  // One-cycle pulse
    output logic              instr_busy_o,

    // Arbiter side
    output logic              req_o,
    output logic [addr_w-1:0] addr_o,
    input  logic              ack_i,
    input  logic [data_w-1:0] rdata_i
);

    logic              pending_q;   // Read request outstanding
    logic              ack_seen_q;  // Ack taken, valid pulse next
    logic [addr_w-1:0] addr_q;
    logic [data_w-1:0] word_q;      // Word captured on the ack edge
    logic              accept;

    // Busy covers the wait for the ack and the cycle before the valid pulse
    assign instr_busy_o = pending_q | ack_seen_q;
    assign accept       = instr_req_i & ~instr_busy_o;

    always_ff @(posedge clk_core) begin
        if (!rst_n_i) begin
            pending_q  <= 1'b0;
            ack_seen_q <= 1'b0;
        end else begin
            ack_seen_q <= pending_q & ack_i;
            if (ack_i) begin
                pending_q <= 1'b0;  // Request drops after its ack
            end else if (accept) begin
                pending_q <= 1'b1;
            end
        end
    end

    // Fetch address held for the whole request
    always_ff @(posedge clk_core) begin
        if (accept) begin
            addr_q <= instr_addr_i;
        end
    end

    always_ff @(posedge clk_core) begin
        if (pending_q && ack_i) begin
            word_q <= rdata_i;
        end
    end

    // Output stage, word and pulse leave together
    always_ff @(posedge clk_core) begin
        if (!rst_n_i) begin
            instr_valid_o <= 1'b0;
        end else begin
            instr_valid_o <= ack_seen_q;
        end
    end

    always_ff @(posedge clk_core) begin
        if (ack_seen_q) begin
            instr_o <= word_q;
        end
    end

    assign req_o  = pending_q;
    assign addr_o = addr_q;

endmodule

// File: src/corebus_pkg.sv
package corebus_pkg;

    // Bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;  // One strobe per byte lane

    // Direction of a memory transfer
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_e;

    // Which port owns the shared bus
    typedef enum logic [1:0] {
        arb_idle  = 2'd0,
        arb_instr = 2'd1,
        arb_data  = 2'd2
    } arb_state_e;

endpackage
